// File: include/stamofu_settings.svh
// STAMOFU pipeline settings

`ifndef STAMOFU_SETTINGS_SVH
`define STAMOFU_SETTINGS_SVH

// ------------------------------------------------
// datapath widths

// data and virtual address width
`define STAMOFU_XLEN 32

// page offset width
// word offset drops the low two bits
`define STAMOFU_VPN_W 20

`define STAMOFU_PO_W 12

// completion queue index
`define STAMOFU_CQ_INDEX_W 3

// ------------------------------------------------
// buffer depths

`define STAMOFU_ISSUE_DEPTH 2
`define STAMOFU_RR_DEPTH 3

`endif

// File: logic/stamofu_pkg.sv
// STAMOFU pipeline types

`default_nettype none

`include "stamofu_settings.svh"

package stamofu_pkg;

    // one-hot operation class
    typedef struct packed {
        logic is_store;
        logic is_amo;
        logic is_fence;
    } stamofu_kind_t;

    // one issued operation
    // op[1] word, op[0] half, neither byte (stores)
    typedef struct packed {
        stamofu_kind_t                   kind;
        logic [3:0]                      op;
        logic [11:0]                     imm12;
        logic                            a_is_reg;
        logic                            b_is_reg;
        logic [`STAMOFU_CQ_INDEX_W-1:0]  cq_index;
    } stamofu_op_t;

    // align decode result
    typedef struct packed {
        logic [3:0]                byte_mask;
        logic                      misaligned;
        logic                      misaligned_exception;
        logic [`STAMOFU_XLEN-1:0]  write_data;
    } stamofu_align_t;

    // outgoing request
    typedef struct packed {
        stamofu_kind_t                   kind;
        logic [3:0]                      op;
        logic                            is_mq;
        logic                            misaligned;
        logic                            misaligned_exception;
        logic [`STAMOFU_VPN_W-1:0]       vpn;
        logic [`STAMOFU_PO_W-3:0]        po_word;
        logic [3:0]                      byte_mask;
        logic [`STAMOFU_XLEN-1:0]        write_data;
        logic [`STAMOFU_CQ_INDEX_W-1:0]  cq_index;
    } stamofu_req_t;

endpackage

`default_nettype wire

// File: logic/stamofu_fifo.sv
// First-word-fall-through queue

`timescale 1ns/1ns
`default_nettype none

module stamofu_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 2
) (
    input  wire logic              CLK,
    input  wire logic              nRST,
    input  wire logic              enq_valid,
    input  wire logic [WIDTH-1:0]  enq_data,
    output logic                   enq_ready,
    output logic                   deq_valid,
    output logic [WIDTH-1:0]       deq_data,
    input  wire logic              deq_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_enq;
    logic             do_deq;

    // pointer step with wrap at DEPTH
    function automatic logic [PTR_W-1:0] ptr_step(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign enq_ready = (count != CNT_W'(DEPTH));
    assign deq_valid = (count != '0);
    assign deq_data  = mem[rd_ptr];
    assign do_enq    = enq_valid & enq_ready;
    assign do_deq    = deq_valid & deq_ready;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= ptr_step(wr_ptr);
            end
            if (do_deq) begin
                rd_ptr <= ptr_step(rd_ptr);
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge CLK) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/stamofu_store_align.sv
// STAMOFU byte mask and data align

`timescale 1ns/1ns
`default_nettype none

`include "stamofu_settings.svh"

module stamofu_store_align (
    input  wire stamofu_pkg::stamofu_kind_t  kind,
    input  wire logic [3:0]                  op,
    input  wire logic [1:0]                  offset,
    input  wire logic                        second_half,
    input  wire logic [`STAMOFU_XLEN-1:0]    b_data,
    output stamofu_pkg::stamofu_align_t      align
);

    import stamofu_pkg::*;

    logic [3:0] word_mask;
    logic [3:0] half_mask;

    // ------------------------------------------------
    // first-request masks

    always_comb begin
        case (offset)
            2'd0: word_mask = 4'b1111;
            2'd1: word_mask = 4'b1110;
            2'd2: word_mask = 4'b1100;
            default: word_mask = 4'b1000;
        endcase
    end

    always_comb begin
        case (offset)
            2'd0: half_mask = 4'b0011;
            2'd1: half_mask = 4'b0110;
            2'd2: half_mask = 4'b1100;
            default: half_mask = 4'b1000;
        endcase
    end

    // ------------------------------------------------
    // mask and misalign select

    always_comb begin
        align.misaligned           = 1'b0;
        align.misaligned_exception = kind.is_amo & (offset != 2'd0);
        // AMO and fence keep the word mask
        align.byte_mask            = word_mask;

        if (kind.is_store) begin
            if (op[1]) begin
                align.misaligned = (offset != 2'd0);
                // second half covers the bytes the first one missed
                align.byte_mask  = second_half ? ~word_mask : word_mask;
            end else if (op[0]) begin
                // only offset 3 runs into the next word
                align.misaligned = (offset == 2'd3);
                align.byte_mask  = second_half ? 4'b0001 : half_mask;
            end else begin
                align.byte_mask = 4'b0001 << offset;
            end
        end
    end

    // rotate left by one byte per offset step
    always_comb begin
        case (offset)
            2'd0: align.write_data = b_data;
            2'd1: align.write_data = {b_data[`STAMOFU_XLEN-9:0],
                                      b_data[`STAMOFU_XLEN-1:`STAMOFU_XLEN-8]};
            2'd2: align.write_data = {b_data[`STAMOFU_XLEN-17:0],
                                      b_data[`STAMOFU_XLEN-1:`STAMOFU_XLEN-16]};
            default: align.write_data = {b_data[`STAMOFU_XLEN-25:0],
                                         b_data[`STAMOFU_XLEN-1:`STAMOFU_XLEN-24]};
        endcase
    end

endmodule

`default_nettype wire

// File: logic/stamofu_operand_collect.sv
// STAMOFU operand collection

`timescale 1ns/1ns
`default_nettype none

`include "stamofu_settings.svh"

module stamofu_operand_collect (
    input  wire logic                        CLK,
    input  wire logic                        nRST,

    // issue queue side
    input  wire logic                        issue_valid,
    input  wire stamofu_pkg::stamofu_op_t    issue_op,
    output logic                             issue_ready,

    // register read responses without back-pressure
    input  wire logic                        a_rr_valid,
    input  wire logic [`STAMOFU_XLEN-1:0]    a_rr_data,
    input  wire logic                        b_rr_valid,
    input  wire logic [`STAMOFU_XLEN-1:0]    b_rr_data,

    // towards REQ stage
    output logic                             oc_valid,
    output stamofu_pkg::stamofu_op_t         oc_op,
    output logic [`STAMOFU_XLEN-1:0]         oc_a,
    output logic [`STAMOFU_XLEN-1:0]         oc_b,
    input  wire logic                        oc_take
);

    import stamofu_pkg::*;

    logic                       head_valid;
    logic                       a_buf_valid;
    logic [`STAMOFU_XLEN-1:0]   a_buf_data;
    logic                       b_buf_valid;
    logic [`STAMOFU_XLEN-1:0]   b_buf_data;
    logic                       a_ready;
    logic                       b_ready;

    // ------------------------------------------------
    // issue buffer

    stamofu_fifo #(
        .WIDTH ($bits(stamofu_op_t)),
        .DEPTH (`STAMOFU_ISSUE_DEPTH)
    ) issue_buf_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .enq_valid (issue_valid),
        .enq_data  (issue_op),
        .enq_ready (issue_ready),
        .deq_valid (head_valid),
        .deq_data  (oc_op),
        .deq_ready (oc_take)
    );

    // ------------------------------------------------
    // register response buffers
    // sized for two issue entries plus the op in REQ

    stamofu_fifo #(
        .WIDTH (`STAMOFU_XLEN),
        .DEPTH (`STAMOFU_RR_DEPTH)
    ) a_buf_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .enq_valid (a_rr_valid),
        .enq_data  (a_rr_data),
        .enq_ready (),
        .deq_valid (a_buf_valid),
        .deq_data  (a_buf_data),
        .deq_ready (oc_take & oc_op.a_is_reg)
    );

    stamofu_fifo #(
        .WIDTH (`STAMOFU_XLEN),
        .DEPTH (`STAMOFU_RR_DEPTH)
    ) b_buf_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .enq_valid (b_rr_valid),
        .enq_data  (b_rr_data),
        .enq_ready (),
        .deq_valid (b_buf_valid),
        .deq_data  (b_buf_data),
        .deq_ready (oc_take & oc_op.b_is_reg)
    );

    // operand present or not needed
    assign a_ready  = ~oc_op.a_is_reg | a_buf_valid;
    assign b_ready  = ~oc_op.b_is_reg | b_buf_valid;
    assign oc_valid = head_valid & a_ready & b_ready;

    // zero operands read as zero
    assign oc_a = oc_op.a_is_reg ? a_buf_data : '0;
    assign oc_b = oc_op.b_is_reg ? b_buf_data : '0;

endmodule

`default_nettype wire

// File: logic/stamofu_req_stage.sv
// STAMOFU request stage

`timescale 1ns/1ns
`default_nettype none

`include "stamofu_settings.svh"

module stamofu_req_stage (
    input  wire logic                        CLK,
    input  wire logic                        nRST,

    // from operand collection
    input  wire logic                        oc_valid,
    input  wire stamofu_pkg::stamofu_op_t    oc_op,
    input  wire logic [`STAMOFU_XLEN-1:0]    oc_a,
    input  wire logic [`STAMOFU_XLEN-1:0]    oc_b,
    output logic                             oc_take,

    // request handshake
    output logic                             req_valid,
    output stamofu_pkg::stamofu_req_t        req,
    input  wire logic                        req_ack
);

    import stamofu_pkg::*;

    typedef enum logic [1:0] {
        state_idle,
        state_active,
        state_misaligned
    } req_state_t;

    req_state_t                 state;
    req_state_t                 next_state;
    stamofu_op_t                op_q;
    logic [`STAMOFU_XLEN-1:0]   a_q;
    logic [`STAMOFU_XLEN-1:0]   b_q;
    logic [`STAMOFU_XLEN-1:0]   va;
    logic [`STAMOFU_XLEN-1:0]   next_word_va;
    logic [`STAMOFU_XLEN-1:0]   req_addr;
    logic                       is_mq;
    logic                       last_ack;
    stamofu_align_t             align;

    // ------------------------------------------------
    // address and align decode

    // AMO address is A alone
    assign va = op_q.kind.is_amo ? a_q
                                 : a_q + {{(`STAMOFU_XLEN-12){op_q.imm12[11]}}, op_q.imm12};

    assign is_mq    = (state == state_misaligned);
    assign req_addr = is_mq ? next_word_va : va;

    stamofu_store_align align_i (
        .kind        (op_q.kind),
        .op          (op_q.op),
        .offset      (va[1:0]),
        .second_half (is_mq),
        .b_data      (b_q),
        .align       (align)
    );

    // ------------------------------------------------
    // handshake and state machine

    // final request of the current op leaves this cycle
    assign last_ack = req_ack & (((state == state_active) & ~align.misaligned) | is_mq);
    assign oc_take  = oc_valid & ((state == state_idle) | last_ack);

    always_comb begin
        next_state = state;
        case (state)
            state_idle: begin
                if (oc_take) begin
                    next_state = state_active;
                end
            end
            state_active: begin
                if (req_ack) begin
                    if (align.misaligned) begin
                        next_state = state_misaligned;
                    end else begin
                        next_state = oc_take ? state_active : state_idle;
                    end
                end
            end
            state_misaligned: begin
                if (req_ack) begin
                    next_state = oc_take ? state_active : state_idle;
                end
            end
            default: next_state = state_idle;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= state_idle;
        end else begin
            state <= next_state;
        end
    end

    // operation payload
    always_ff @(posedge CLK) begin
        if (oc_take) begin
            op_q <= oc_op;
            a_q  <= oc_a;
            b_q  <= oc_b;
        end
        // word after the first half for the split request
        if ((state == state_active) && req_ack && align.misaligned) begin
            next_word_va <= {va[`STAMOFU_XLEN-1:2] + 1'b1, 2'b00};
        end
    end

    // ------------------------------------------------
    // request formatting

    assign req_valid = (state != state_idle);

    always_comb begin
        req.kind                 = op_q.kind;
        req.op                   = op_q.op;
        req.is_mq                = is_mq;
        req.misaligned           = align.misaligned;
        req.misaligned_exception = align.misaligned_exception;
        req.vpn                  = req_addr[`STAMOFU_XLEN-1 -: `STAMOFU_VPN_W];
        req.po_word              = req_addr[`STAMOFU_PO_W-1:2];
        req.byte_mask            = align.byte_mask;
        req.write_data           = align.write_data;
        req.cq_index             = op_q.cq_index;
    end

endmodule

`default_nettype wire

// File: logic/stamofu_addr_pipeline.sv
// STAMOFU address pipeline top

`timescale 1ns/1ns
`default_nettype none

`include "stamofu_settings.svh"

module stamofu_addr_pipeline (
    input  wire logic                        CLK,
    input  wire logic                        nRST,

    // issue
    input  wire logic                        issue_valid,
    input  wire stamofu_pkg::stamofu_op_t    issue_op,
    output logic                             issue_ready,

    // register read responses
    input  wire logic                        a_rr_valid,
    input  wire logic [`STAMOFU_XLEN-1:0]    a_rr_data,
    input  wire logic                        b_rr_valid,
    input  wire logic [`STAMOFU_XLEN-1:0]    b_rr_data,

    // request out
    output logic                             req_valid,
    output stamofu_pkg::stamofu_req_t        req,
    input  wire logic                        req_ack
);

    import stamofu_pkg::*;

    logic                       oc_valid;
    stamofu_op_t                oc_op;
    logic [`STAMOFU_XLEN-1:0]   oc_a;
    logic [`STAMOFU_XLEN-1:0]   oc_b;
    logic                       oc_take;

    stamofu_operand_collect collect_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_ready (issue_ready),
        .a_rr_valid  (a_rr_valid),
        .a_rr_data   (a_rr_data),
        .b_rr_valid  (b_rr_valid),
        .b_rr_data   (b_rr_data),
        .oc_valid    (oc_valid),
        .oc_op       (oc_op),
        .oc_a        (oc_a),
        .oc_b        (oc_b),
        .oc_take     (oc_take)
    );

    stamofu_req_stage req_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .oc_valid  (oc_valid),
        .oc_op     (oc_op),
        .oc_a      (oc_a),
        .oc_b      (oc_b),
        .oc_take   (oc_take),
        .req_valid (req_valid),
        .req       (req),
        .req_ack   (req_ack)
    );

endmodule

`default_nettype wire

// File: testbench/stamofu_tb.sv
// STAMOFU address pipeline testbench

`timescale 1ns/1ns
`default_nettype none

`include "stamofu_settings.svh"

module stamofu_tb;

    import stamofu_pkg::*;

    localparam int MAX_OPS = 64;
    localparam int TIMEOUT = 200;

    logic                       CLK;
    logic                       nRST;
    logic                       issue_valid;
    stamofu_op_t                issue_op;
    logic                       issue_ready;
    logic                       a_rr_valid;
    logic [`STAMOFU_XLEN-1:0]   a_rr_data;
    logic                       b_rr_valid;
    logic [`STAMOFU_XLEN-1:0]   b_rr_data;
    logic                       req_valid;
    stamofu_req_t               req;
    logic                       req_ack;

    // operations and expected requests in issue order
    stamofu_op_t                ops [MAX_OPS];
    logic [`STAMOFU_XLEN-1:0]   op_a [MAX_OPS];
    logic [`STAMOFU_XLEN-1:0]   op_b [MAX_OPS];
    int                         num_ops;
    stamofu_req_t               want_q [$];

    integer                     seed;
    logic                       saw_full;

    stamofu_addr_pipeline dut_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_ready (issue_ready),
        .a_rr_valid  (a_rr_valid),
        .a_rr_data   (a_rr_data),
        .b_rr_valid  (b_rr_valid),
        .b_rr_data   (b_rr_data),
        .req_valid   (req_valid),
        .req         (req),
        .req_ack     (req_ack)
    );

    always #50 CLK = ~CLK;

    // --------------------------------------------------
    // error handling

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] want);
        if (got !== want) begin
            abort_run($sformatf("FAIL at %0t ns: %s got %0h expected %0h",
                                $time, name, got, want));
        end
    endtask

    // --------------------------------------------------
    // stimulus file

    task automatic load_stimulus();
        int           fd;
        int           n;
        string        line;
        logic [31:0]  f_kind, f_op, f_imm, f_a, f_b, f_areg, f_breg, f_cq, f_nreq;
        logic [31:0]  vpn0, po0, mask0, data0, mq0, ex0;
        logic [31:0]  vpn1, po1, mask1, data1, mq1, ex1;
        stamofu_req_t r;
        fd = $fopen("testbench/stamofu_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("could not open testbench/stamofu_stimulus.txt");
        end
        num_ops = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f_kind, f_op, f_imm, f_a, f_b, f_areg, f_breg, f_cq, f_nreq,
                        vpn0, po0, mask0, data0, mq0, ex0,
                        vpn1, po1, mask1, data1, mq1, ex1);
            if (n != 21 || num_ops == MAX_OPS || f_nreq < 1 || f_nreq > 2) begin
                abort_run($sformatf("bad stimulus line: %s", line));
            end
            ops[num_ops].kind     = f_kind[2:0];
            ops[num_ops].op       = f_op[3:0];
            ops[num_ops].imm12    = f_imm[11:0];
            ops[num_ops].a_is_reg = f_areg[0];
            ops[num_ops].b_is_reg = f_breg[0];
            ops[num_ops].cq_index = f_cq[`STAMOFU_CQ_INDEX_W-1:0];
            op_a[num_ops]         = f_a;
            op_b[num_ops]         = f_b;

            // both halves of a split carry the misaligned flag
            r.kind                 = ops[num_ops].kind;
            r.op                   = ops[num_ops].op;
            r.cq_index             = ops[num_ops].cq_index;
            r.misaligned           = (f_nreq == 2);
            r.is_mq                = mq0[0];
            r.misaligned_exception = ex0[0];
            r.vpn                  = vpn0[`STAMOFU_VPN_W-1:0];
            r.po_word              = po0[`STAMOFU_PO_W-3:0];
            r.byte_mask            = mask0[3:0];
            r.write_data           = data0;
            want_q.push_back(r);
            if (f_nreq == 2) begin
                r.is_mq                = mq1[0];
                r.misaligned_exception = ex1[0];
                r.vpn                  = vpn1[`STAMOFU_VPN_W-1:0];
                r.po_word              = po1[`STAMOFU_PO_W-3:0];
                r.byte_mask            = mask1[3:0];
                r.write_data           = data1;
                want_q.push_back(r);
            end
            num_ops++;
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // issue and register response driver

    task automatic drive_issue();
        int waited;
        for (int i = 0; i < num_ops; i++) begin
            issue_valid = 1'b1;
            issue_op    = ops[i];
            waited      = 0;
            // issue_ready only moves on the rising edge
            while (!issue_ready) begin
                saw_full = 1'b1;
                @(negedge CLK);
                a_rr_valid = 1'b0;
                b_rr_valid = 1'b0;
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run("timed out waiting for issue_ready");
                end
            end
            @(negedge CLK);
            // operands follow the transfer by one cycle
            a_rr_valid = ops[i].a_is_reg;
            a_rr_data  = op_a[i];
            b_rr_valid = ops[i].b_is_reg;
            b_rr_data  = op_b[i];
        end
        issue_valid = 1'b0;
        @(negedge CLK);
        a_rr_valid = 1'b0;
        b_rr_valid = 1'b0;
    endtask

    // --------------------------------------------------
    // ack model and request checker

    task automatic collect_requests();
        stamofu_req_t want;
        stamofu_req_t held;
        int           waited;
        int           delay;
        int           k;
        k = 0;
        while (want_q.size() != 0) begin
            want   = want_q.pop_front();
            waited = 0;
            while (!req_valid) begin
                @(negedge CLK);
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run($sformatf("timed out waiting for request %0d", k));
                end
            end
            held  = req;
            delay = $unsigned($random(seed)) % 4;
            // request must hold while unacked
            repeat (delay) begin
                @(negedge CLK);
                check("req_valid", 128'(req_valid), 128'(1'b1));
                check("req", 128'(req), 128'(held));
            end
            check("req.kind", 128'(req.kind), 128'(want.kind));
            check("req.op", 128'(req.op), 128'(want.op));
            check("req.cq_index", 128'(req.cq_index), 128'(want.cq_index));
            check("req.is_mq", 128'(req.is_mq), 128'(want.is_mq));
            check("req.misaligned", 128'(req.misaligned), 128'(want.misaligned));
            check("req.misaligned_exception", 128'(req.misaligned_exception),
                  128'(want.misaligned_exception));
            check("req.vpn", 128'(req.vpn), 128'(want.vpn));
            check("req.po_word", 128'(req.po_word), 128'(want.po_word));
            check("req.byte_mask", 128'(req.byte_mask), 128'(want.byte_mask));
            check("req.write_data", 128'(req.write_data), 128'(want.write_data));
            req_ack = 1'b1;
            @(negedge CLK);
            req_ack = 1'b0;
            k++;
        end
    endtask

    initial begin
        seed        = 94;
        saw_full    = 1'b0;
        CLK         = 1'b0;
        nRST        = 1'b0;
        issue_valid = 1'b0;
        issue_op    = '0;
        a_rr_valid  = 1'b0;
        a_rr_data   = '0;
        b_rr_valid  = 1'b0;
        b_rr_data   = '0;
        req_ack     = 1'b0;
        load_stimulus();

        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        check("req_valid", 128'(req_valid), 128'(1'b0));
        check("issue_ready", 128'(issue_ready), 128'(1'b1));

        fork
            drive_issue();
            collect_requests();
        join

        // nothing beyond the expected requests
        repeat (4) @(negedge CLK);
        check("req_valid", 128'(req_valid), 128'(1'b0));
        if (!saw_full) begin
            abort_run("issue_ready never fell while the buffers were full");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/stamofu_stimulus.txt
# kind op imm12 a b a_is_reg b_is_reg cq nreq, then per request: vpn po_word mask data is_mq exc
# kind 4 store, 2 amo, 1 fence; second request fields are zero when nreq is 1
4 2 010 00001000 11223344 1 1 0 1 00001 004 f 11223344 0 0 00000 000 0 00000000 0 0
4 1 ffc 00002008 aabbccdd 1 1 1 1 00002 001 3 aabbccdd 0 0 00000 000 0 00000000 0 0
4 0 000 00003100 000000ef 1 1 2 1 00003 040 1 000000ef 0 0 00000 000 0 00000000 0 0
4 0 002 00003100 000000ef 1 1 3 1 00003 040 4 00ef0000 0 0 00000 000 0 00000000 0 0
4 2 001 00004000 11223344 1 1 4 2 00004 000 e 22334411 0 0 00004 001 1 22334411 1 0
4 2 002 00004ffc 11223344 1 1 5 2 00004 3ff c 33441122 0 0 00005 000 3 33441122 1 0
4 2 7ff 00006000 deadbeef 1 1 6 2 00006 1ff 8 efdeadbe 0 0 00006 200 7 efdeadbe 1 0
4 2 800 00010000 01020304 1 1 7 1 0000f 200 f 01020304 0 0 00000 000 0 00000000 0 0
4 1 000 00007003 0000abcd 1 1 0 2 00007 000 8 cd0000ab 0 0 00007 001 1 cd0000ab 1 0
4 1 001 00007000 0000abcd 1 1 1 1 00007 000 6 00abcd00 0 0 00000 000 0 00000000 0 0
4 1 002 00007000 0000abcd 1 1 2 1 00007 000 c abcd0000 0 0 00000 000 0 00000000 0 0
2 5 123 00008010 55667788 1 1 3 1 00008 004 f 55667788 0 0 00000 000 0 00000000 0 0
2 5 7ff 00008012 55667788 1 1 4 1 00008 004 c 77885566 0 1 00000 000 0 00000000 0 0
2 5 fff 00009001 00000001 1 1 5 1 00009 000 e 00000100 0 1 00000 000 0 00000000 0 0
1 0 000 00000000 00000000 0 0 6 1 00000 000 f 00000000 0 0 00000 000 0 00000000 0 0
1 0 004 0000a000 00000000 1 0 7 1 0000a 001 f 00000000 0 0 00000 000 0 00000000 0 0
4 2 100 00000000 cafef00d 0 1 0 1 00000 040 f cafef00d 0 0 00000 000 0 00000000 0 0
4 0 000 0000b003 00000000 1 0 1 1 0000b 000 8 00000000 0 0 00000 000 0 00000000 0 0
4 2 003 00000000 a1b2c3d4 0 1 2 2 00000 000 8 d4a1b2c3 0 0 00000 001 7 d4a1b2c3 1 0
4 0 001 0000c000 00000077 1 1 3 1 0000c 000 2 00007700 0 0 00000 000 0 00000000 0 0
4 2 008 fffff000 12345678 1 1 4 1 fffff 002 f 12345678 0 0 00000 000 0 00000000 0 0
4 2 001 fffffffc 12345678 1 1 5 2 fffff 3ff e 34567812 0 0 00000 000 1 34567812 1 0
4 1 ff0 0000d010 0000beef 1 1 6 1 0000d 000 3 0000beef 0 0 00000 000 0 00000000 0 0
2 5 000 0000e003 11223344 1 1 7 1 0000e 000 8 44112233 0 1 00000 000 0 00000000 0 0

// File: vlog.f
+incdir+include
logic/stamofu_pkg.sv
logic/stamofu_fifo.sv
logic/stamofu_store_align.sv
logic/stamofu_operand_collect.sv
logic/stamofu_req_stage.sv
logic/stamofu_addr_pipeline.sv
testbench/stamofu_tb.sv

// File: Makefile
TOP := stamofu_tb
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

run: build
	./$(OBJ)/$(TOP)

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module stamofu_addr_pipeline

clean:
	rm -rf $(OBJ)
